// ==== Makefile ====
# Verilator build and run for the LPIF slave loopback testbench

TOP := lpif_slave_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
verilog/lpif_pkg.sv
verilog/ll_auto_sync.sv
verilog/lpif_slave_name.sv
verilog/lpif_slave_concat.sv
verilog/lpif_slave_top.sv
test/lpif_slave_tb.sv

// ==== test/lpif_slave_tb.sv ====
// Loopback testbench for the LPIF slave with clock, reset, value check and directed tests

`timescale 1ns/1ps

module lpif_slave_tb;

  localparam int          CLK_HALF   = 5;
  localparam int          RST_CYCLES = 5;
  localparam int          WAIT_LIMIT = 100;
  localparam int          NUM_WORDS  = 20;
  localparam logic [31:0] SEED       = 32'h54d07ea4;
  // Clears lane bit 39, the strobe
  localparam logic [39:0] STB_CLR    = 40'h7f_ffff_ffff;

  logic                          clk_wr;
  logic                          rst_n;
  logic                          tx_online;
  logic                          rx_online;
  logic [lpif_pkg::DELAY_W-1:0]  delay_x_value;
  logic [lpif_pkg::DELAY_W-1:0]  delay_y_value;
  logic [lpif_pkg::DELAY_W-1:0]  delay_z_value;
  lpif_pkg::link_word_t          ustrm;

  // Downstream fields, regrouped into one word below
  logic [3:0]                    dstrm_state;
  logic [1:0]                    dstrm_protid;
  logic [63:0]                   dstrm_data;
  logic                          dstrm_dvalid;
  logic [1:0]                    dstrm_crc;
  logic                          dstrm_crc_valid;
  logic                          dstrm_valid;
  lpif_pkg::link_word_t          dstrm_now;

  logic [39:0]                   tx_phy0;
  logic [39:0]                   tx_phy1;
  logic [39:0]                   rx_phy0;
  logic [39:0]                   rx_phy1;
  logic [31:0]                   rx_dbg;
  logic [31:0]                   tx_dbg;

  // Lane corruption control and expected counts
  logic                          drop_stb1;
  int unsigned                   tx_valid_cnt;
  int unsigned                   rx_valid_cnt;

  initial clk_wr = 1'b0;
  always #CLK_HALF clk_wr = ~clk_wr;

  ////////////////////////////////////////////////////////////////////////////
  // DUT and loopback

  lpif_slave_top dut_i (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .ustrm_state                (ustrm.state),
    .ustrm_protid               (ustrm.protid),
    .ustrm_data                 (ustrm.data),
    .ustrm_dvalid               (ustrm.dvalid),
    .ustrm_crc                  (ustrm.crc),
    .ustrm_crc_valid            (ustrm.crc_valid),
    .ustrm_valid                (ustrm.valid),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .rx_downstream_debug_status (rx_dbg),
    .tx_upstream_debug_status   (tx_dbg)
  );

  assign dstrm_now = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                      dstrm_crc, dstrm_crc_valid, dstrm_valid};

  // Tx lanes fed straight back, lane 1 strobe can be knocked out
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = drop_stb1 ? (tx_phy1 & STB_CLR) : tx_phy1;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
      stop_run("value check failed");
    end
  endtask

  // Outputs settled, inputs driven 1 ns after the edge
  task automatic step_clk();
    @(posedge clk_wr);
    #1;
  endtask

  function automatic lpif_pkg::link_word_t random_word();
    lpif_pkg::link_word_t w;
    w.state     = 4'($urandom);
    w.protid    = 2'($urandom);
    w.data      = {$urandom, $urandom};
    w.dvalid    = 1'($urandom);
    w.crc       = 2'($urandom);
    w.crc_valid = 1'($urandom);
    w.valid     = 1'($urandom);
    return w;
  endfunction

  // Lane 0: strobe at 39, marker 38 zero, word bits 37..0
  function automatic logic [39:0] lane0_expect(input lpif_pkg::link_word_t w,
                                               input logic data_on);
    logic [39:0] l;
    l     = '0;
    l[39] = 1'b1;
    if (data_on) l[37:0] = w[37:0];
    return l;
  endfunction

  // Lane 1: strobe at 39, bits 38..37 zero, word bits 74..38
  function automatic logic [39:0] lane1_expect(input lpif_pkg::link_word_t w,
                                               input logic data_on);
    logic [39:0] l;
    l     = '0;
    l[39] = 1'b1;
    if (data_on) l[36:0] = w[74:38];
    return l;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic reset_state();
    check_eq(tx_phy0, '0, "tx_phy0 after reset");
    check_eq(tx_phy1, '0, "tx_phy1 after reset");
    check_eq(dstrm_now, '0, "downstream fields after reset");
    check_eq(rx_dbg, '0, "rx debug status after reset");
    check_eq(tx_dbg, '0, "tx debug status after reset");
  endtask

  task automatic tx_delay_timing();
    lpif_pkg::link_word_t w;
    int                   n;
    logic                 seen;
    w       = random_word();
    // Nonzero payload, no valid so the counters stay put
    w.state = 4'ha;
    w.valid = 1'b0;
    ustrm         = w;
    delay_y_value = 16'd4;
    delay_z_value = 16'd3;
    tx_online     = 1'b1;
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      step_clk();
      n++;
      if (n > WAIT_LIMIT) stop_run("timeout waiting for the tx lane strobe");
      seen = (tx_phy0[39] === 1'b1);
      if (!seen) begin
        check_eq(tx_phy0, '0, "lane 0 before tx online");
        check_eq(tx_phy1, '0, "lane 1 before tx online");
      end
    end
    // Sampling edge, y waits, then the lane register
    check_eq(n, delay_y_value + 2, "edges from tx_online to lane strobe");
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      seen = (tx_phy0[37:0] != '0) || (tx_phy1[36:0] != '0);
      if (!seen) begin
        check_eq(tx_phy0, lane0_expect(w, 1'b0), "lane 0 strobe only");
        check_eq(tx_phy1, lane1_expect(w, 1'b0), "lane 1 strobe only");
        step_clk();
        n++;
        if (n > WAIT_LIMIT) stop_run("timeout waiting for tx payload");
      end
    end
    check_eq(n, delay_z_value, "edges from lane strobe to payload");
    check_eq(tx_phy0, lane0_expect(w, 1'b1), "lane 0 first payload");
    check_eq(tx_phy1, lane1_expect(w, 1'b1), "lane 1 first payload");
  endtask

  task automatic rx_gating();
    int   n;
    logic seen;
    delay_x_value = 16'd6;
    rx_online     = 1'b1;
    n    = 0;
    seen = 1'b0;
    while (!seen) begin
      step_clk();
      n++;
      if (n > WAIT_LIMIT) stop_run("timeout waiting for downstream data");
      seen = (dstrm_now != '0);
      // Lanes keep arriving while rx is held off
      if (!seen) check_eq(rx_phy0[39], 1'b1, "strobed lane while rx gated");
    end
    check_eq(n, delay_x_value + 2, "edges from rx_online to downstream data");
    check_eq(dstrm_now, ustrm, "first delivered word");
  endtask

  task automatic loopback_words();
    lpif_pkg::link_word_t sent[$];
    lpif_pkg::link_word_t w;
    lpif_pkg::link_word_t exp;
    int                   c;
    for (c = 0; c < NUM_WORDS + 2; c++) begin
      // Word driven two cycles back is on the downstream fields now
      if (c >= 2) begin
        exp = sent.pop_front();
        check_eq(dstrm_now, exp, $sformatf("loopback word %0d", c - 2));
      end
      if (c < NUM_WORDS) begin
        w = random_word();
        sent.push_back(w);
        ustrm = w;
        if (w.valid) begin
          tx_valid_cnt++;
          rx_valid_cnt++;
        end
      end else begin
        ustrm = '0;
      end
      step_clk();
    end
  endtask

  task automatic strobe_drop();
    lpif_pkg::link_word_t a;
    lpif_pkg::link_word_t b;
    a       = random_word();
    a.valid = 1'b1;
    b       = random_word();
    b.valid = 1'b1;
    ustrm = a;
    step_clk();
    // Word a is on the lanes now
    drop_stb1 = 1'b1;
    ustrm     = b;
    step_clk();
    drop_stb1 = 1'b0;
    ustrm     = '0;
    check_eq(dstrm_now, '0, "word with lane 1 strobe cleared");
    step_clk();
    check_eq(dstrm_now, b, "word after the dropped one");
    tx_valid_cnt += 2;
    rx_valid_cnt += 1;
  endtask

  task automatic debug_counts();
    step_clk();
    check_eq(tx_dbg, tx_valid_cnt, "tx upstream debug count");
    check_eq(rx_dbg, rx_valid_cnt, "rx downstream debug count");
    tx_online = 1'b0;
    // Online flag drops on the first edge, lane register on the next
    step_clk();
    step_clk();
    check_eq(tx_phy0, '0, "lane 0 after tx offline");
    check_eq(tx_phy1, '0, "lane 1 after tx offline");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int unsigned seed_ret;
    seed_ret      = $urandom(SEED);
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    ustrm         = '0;
    drop_stb1     = 1'b0;
    tx_valid_cnt  = 0;
    rx_valid_cnt  = 0;
    repeat (RST_CYCLES) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;
    reset_state();
    tx_delay_timing();
    rx_gating();
    loopback_words();
    strobe_drop();
    debug_counts();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== verilog/ll_auto_sync.sv ====
// Online delay state machines for tx and rx, persistent strobe userbit

`timescale 1ns/1ps

module ll_auto_sync (
  input  logic                         clk_wr,
  input  logic                         rst_n,

  // Raw online requests
  input  logic                         tx_online,
  input  logic                         rx_online,

  // Programmed delays in clk_wr cycles
  input  logic [lpif_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_y_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_z_value,

  // Delayed flags to the lane logic
  output logic                         tx_online_delay,
  output logic                         tx_data_en,
  output logic                         rx_online_delay,
  output logic                         tx_stb_userbit
);

  // Current state and down-counter per wait
  lpif_pkg::sync_state_e         rx_st, rx_st_nxt;
  lpif_pkg::sync_state_e         tx_st, tx_st_nxt;
  lpif_pkg::sync_state_e         en_st, en_st_nxt;
  logic [lpif_pkg::DELAY_W-1:0]  rx_cnt, rx_cnt_nxt;
  logic [lpif_pkg::DELAY_W-1:0]  tx_cnt, tx_cnt_nxt;
  logic [lpif_pkg::DELAY_W-1:0]  en_cnt, en_cnt_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // One step of a delay machine

  // First high sample loads dly-1, so ON lands exactly dly edges later
  function automatic void sync_step(
    input  logic                         go,
    input  lpif_pkg::sync_state_e        st,
    input  logic [lpif_pkg::DELAY_W-1:0] cnt,
    input  logic [lpif_pkg::DELAY_W-1:0] dly,
    output lpif_pkg::sync_state_e        st_nxt,
    output logic [lpif_pkg::DELAY_W-1:0] cnt_nxt
  );
    st_nxt  = st;
    cnt_nxt = cnt;
    if (!go) begin
      st_nxt  = lpif_pkg::SYNC_OFF;
      cnt_nxt = '0;
    end else begin
      case (st)
        lpif_pkg::SYNC_OFF: begin
          // Zero delay goes straight on
          if (dly == '0) begin
            st_nxt = lpif_pkg::SYNC_ON;
          end else begin
            st_nxt  = lpif_pkg::SYNC_WAIT;
            cnt_nxt = dly - 1'b1;
          end
        end
        lpif_pkg::SYNC_WAIT: begin
          if (cnt == '0) begin
            st_nxt = lpif_pkg::SYNC_ON;
          end else begin
            cnt_nxt = cnt - 1'b1;
          end
        end
        default: st_nxt = lpif_pkg::SYNC_ON;
      endcase
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    // Rx side, x wait
    sync_step(rx_online, rx_st, rx_cnt, delay_x_value, rx_st_nxt, rx_cnt_nxt);
    // Tx side, y wait
    sync_step(tx_online, tx_st, tx_cnt, delay_y_value, tx_st_nxt, tx_cnt_nxt);
    // z wait starts on the edge where tx goes online
    sync_step(tx_st_nxt == lpif_pkg::SYNC_ON, en_st, en_cnt, delay_z_value,
              en_st_nxt, en_cnt_nxt);
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_st  <= lpif_pkg::SYNC_OFF;
      tx_st  <= lpif_pkg::SYNC_OFF;
      en_st  <= lpif_pkg::SYNC_OFF;
      rx_cnt <= '0;
      tx_cnt <= '0;
      en_cnt <= '0;
    end else begin
      rx_st  <= rx_st_nxt;
      tx_st  <= tx_st_nxt;
      en_st  <= en_st_nxt;
      rx_cnt <= rx_cnt_nxt;
      tx_cnt <= tx_cnt_nxt;
      en_cnt <= en_cnt_nxt;
    end
  end

  // Flags decode straight from state
  assign rx_online_delay = (rx_st == lpif_pkg::SYNC_ON);
  assign tx_online_delay = (tx_st == lpif_pkg::SYNC_ON);
  assign tx_data_en      = (en_st == lpif_pkg::SYNC_ON);

  // Persistent strobe, on for as long as tx is online
  assign tx_stb_userbit  = tx_online_delay;

  // Data enable must sit inside the tx online window
  a_en_in_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_data_en |-> tx_online_delay);

endmodule

// ==== verilog/lpif_pkg.sv ====
// Link word struct, lane layout constants and auto-sync state encoding

package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // PHY lane geometry

  // One PHY lane per direction per slice
  localparam int LANE_W     = 40;

  // Payload split, lane 0 takes the low part of the link word
  localparam int LANE0_BITS = 38;
  localparam int LANE1_BITS = 37;

  // Full link word width across both lanes
  localparam int LINK_W     = LANE0_BITS + LANE1_BITS;

  // Per-lane sideband positions
  localparam int STB_BIT    = 39;
  // Marker slot, held at zero since there are no user markers
  localparam int MRK_BIT    = 38;

  ////////////////////////////////////////////////////////////////////////////
  // Config and status widths

  // Online delay programming
  localparam int DELAY_W    = 16;
  // Debug status words
  localparam int DBG_W      = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Link word, MSB first

  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [63:0] data;
    // Data qualifier
    logic        dvalid;
    logic [1:0]  crc;
    logic        crc_valid;
    // Word qualifier, bit 0 of the link word
    logic        valid;
  } link_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Auto-sync per-direction states

  typedef enum logic [1:0] {
    // Online input low
    SYNC_OFF  = 2'd0,
    // Counting down the programmed delay
    SYNC_WAIT = 2'd1,
    // Delayed flag asserted
    SYNC_ON   = 2'd2
  } sync_state_e;

endpackage

// ==== verilog/lpif_slave_concat.sv ====
// Lane split and reassembly, strobe check, online gating and debug counters

`timescale 1ns/1ps

module lpif_slave_concat (
  input  logic                        clk_wr,
  input  logic                        rst_n,

  // From auto-sync
  input  logic                        tx_online_delay,
  input  logic                        tx_data_en,
  input  logic                        rx_online_delay,
  input  logic                        tx_stb_userbit,

  // Link words to and from the user interface
  input  lpif_pkg::link_word_t        ustrm_word,
  output lpif_pkg::link_word_t        dstrm_word,

  // PHY lanes
  output logic [lpif_pkg::LANE_W-1:0] tx_phy0,
  output logic [lpif_pkg::LANE_W-1:0] tx_phy1,
  input  logic [lpif_pkg::LANE_W-1:0] rx_phy0,
  input  logic [lpif_pkg::LANE_W-1:0] rx_phy1,

  // Debug status
  output logic [lpif_pkg::DBG_W-1:0]  rx_downstream_debug_status,
  output logic [lpif_pkg::DBG_W-1:0]  tx_upstream_debug_status
);

  // Flat view of the outgoing word for slicing
  logic [lpif_pkg::LINK_W-1:0] tx_word_bits;
  logic [lpif_pkg::LANE_W-1:0] tx_lane0_nxt;
  logic [lpif_pkg::LANE_W-1:0] tx_lane1_nxt;
  logic                        tx_sent_valid;

  // Receive side
  lpif_pkg::link_word_t        rx_word;
  logic                        rx_stb_ok;
  logic                        rx_take;

  // Word counters
  logic [lpif_pkg::DBG_W-1:0]  tx_cnt;
  logic [lpif_pkg::DBG_W-1:0]  rx_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit lanes

  assign tx_word_bits = ustrm_word;

  always_comb begin
    // Idle lanes are all zero
    tx_lane0_nxt = '0;
    tx_lane1_nxt = '0;
    if (tx_online_delay) begin
      tx_lane0_nxt[lpif_pkg::STB_BIT] = tx_stb_userbit;
      tx_lane1_nxt[lpif_pkg::STB_BIT] = tx_stb_userbit;
      // No user markers
      tx_lane0_nxt[lpif_pkg::MRK_BIT] = 1'b0;
      tx_lane1_nxt[lpif_pkg::MRK_BIT] = 1'b0;
      // Strobe-only until data is enabled
      if (tx_data_en) begin
        tx_lane0_nxt[lpif_pkg::LANE0_BITS-1:0] =
          tx_word_bits[lpif_pkg::LANE0_BITS-1:0];
        // Upper word bits, lane 1 bit 37 stays as pad
        tx_lane1_nxt[lpif_pkg::LANE1_BITS-1:0] =
          tx_word_bits[lpif_pkg::LINK_W-1:lpif_pkg::LANE0_BITS];
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= tx_lane0_nxt;
      tx_phy1 <= tx_lane1_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive lanes

  // Reassemble, lane 1 on top
  assign rx_word = {rx_phy1[lpif_pkg::LANE1_BITS-1:0],
                    rx_phy0[lpif_pkg::LANE0_BITS-1:0]};

  // Both lanes must carry the strobe
  assign rx_stb_ok = rx_phy0[lpif_pkg::STB_BIT] & rx_phy1[lpif_pkg::STB_BIT];
  assign rx_take   = rx_online_delay & rx_stb_ok;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      dstrm_word <= '0;
    end else if (rx_take) begin
      dstrm_word <= rx_word;
    end else begin
      // Dropped or offline, present an empty word
      dstrm_word <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Debug counters

  // Valid words leaving on the lanes
  assign tx_sent_valid = tx_online_delay & tx_data_en & ustrm_word.valid;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_cnt <= '0;
      rx_cnt <= '0;
    end else begin
      // Saturating counts
      if (tx_sent_valid && (tx_cnt != '1)) begin
        tx_cnt <= tx_cnt + 1'b1;
      end
      if (rx_take && rx_word.valid && (rx_cnt != '1)) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
    end
  end

  assign tx_upstream_debug_status   = tx_cnt;
  assign rx_downstream_debug_status = rx_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // Strobes split across lanes once rx is up, the word gets dropped
  a_rx_stb_match: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_online_delay |->
      (rx_phy0[lpif_pkg::STB_BIT] == rx_phy1[lpif_pkg::STB_BIT]))
    else $warning("lane strobe mismatch at %0t", $time);

endmodule

// ==== verilog/lpif_slave_name.sv ====
// User interface field mapping between LPIF channels and link words

`timescale 1ns/1ps

module lpif_slave_name (
  ////////////////////////////////////////////////////////////////////////////
  // Upstream channel in

  input  logic [3:0]           ustrm_state,
  input  logic [1:0]           ustrm_protid,
  input  logic [63:0]          ustrm_data,
  input  logic                 ustrm_dvalid,
  input  logic [1:0]           ustrm_crc,
  input  logic                 ustrm_crc_valid,
  input  logic                 ustrm_valid,

  // Packed word towards the lanes
  output lpif_pkg::link_word_t ustrm_word,

  ////////////////////////////////////////////////////////////////////////////
  // Downstream channel out

  // Packed word from the lanes
  input  lpif_pkg::link_word_t dstrm_word,

  output logic [3:0]           dstrm_state,
  output logic [1:0]           dstrm_protid,
  output logic [63:0]          dstrm_data,
  output logic                 dstrm_dvalid,
  output logic [1:0]           dstrm_crc,
  output logic                 dstrm_crc_valid,
  output logic                 dstrm_valid
);

  // Upstream pack
  always_comb begin
    ustrm_word.state     = ustrm_state;
    ustrm_word.protid    = ustrm_protid;
    ustrm_word.data      = ustrm_data;
    ustrm_word.dvalid    = ustrm_dvalid;
    // CRC travels with its own qualifier
    ustrm_word.crc       = ustrm_crc;
    ustrm_word.crc_valid = ustrm_crc_valid;
    ustrm_word.valid     = ustrm_valid;
  end

  // Downstream unpack
  always_comb begin
    dstrm_state     = dstrm_word.state;
    dstrm_protid    = dstrm_word.protid;
    dstrm_data      = dstrm_word.data;
    dstrm_dvalid    = dstrm_word.dvalid;
    dstrm_crc       = dstrm_word.crc;
    dstrm_crc_valid = dstrm_word.crc_valid;
    // Zero word from the lane block means no transfer
    dstrm_valid     = dstrm_word.valid;
  end

endmodule

// ==== verilog/lpif_slave_top.sv ====
// Slave top level, auto-sync and user interface feeding the lane block

`timescale 1ns/1ps

module lpif_slave_top (
  input  logic                         clk_wr,
  input  logic                         rst_n,

  // Control
  input  logic                         tx_online,
  input  logic                         rx_online,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_x_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_y_value,
  input  logic [lpif_pkg::DELAY_W-1:0] delay_z_value,

  // Upstream channel
  input  logic [3:0]                   ustrm_state,
  input  logic [1:0]                   ustrm_protid,
  input  logic [63:0]                  ustrm_data,
  input  logic                         ustrm_dvalid,
  input  logic [1:0]                   ustrm_crc,
  input  logic                         ustrm_crc_valid,
  input  logic                         ustrm_valid,

  // Downstream channel
  output logic [3:0]                   dstrm_state,
  output logic [1:0]                   dstrm_protid,
  output logic [63:0]                  dstrm_data,
  output logic                         dstrm_dvalid,
  output logic [1:0]                   dstrm_crc,
  output logic                         dstrm_crc_valid,
  output logic                         dstrm_valid,

  // PHY lanes
  output logic [lpif_pkg::LANE_W-1:0]  tx_phy0,
  output logic [lpif_pkg::LANE_W-1:0]  tx_phy1,
  input  logic [lpif_pkg::LANE_W-1:0]  rx_phy0,
  input  logic [lpif_pkg::LANE_W-1:0]  rx_phy1,

  // Debug status
  output logic [lpif_pkg::DBG_W-1:0]   rx_downstream_debug_status,
  output logic [lpif_pkg::DBG_W-1:0]   tx_upstream_debug_status
);

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect

  logic                 tx_online_delay;
  logic                 tx_data_en;
  logic                 rx_online_delay;
  logic                 tx_stb_userbit;
  lpif_pkg::link_word_t ustrm_word;
  lpif_pkg::link_word_t dstrm_word;

  // Online delays and strobe
  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .tx_data_en      (tx_data_en),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit)
  );

  // Field naming for both channels
  lpif_slave_name u_name (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .ustrm_word      (ustrm_word),
    .dstrm_word      (dstrm_word),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  // Lanes, strobe check, counters
  lpif_slave_concat u_concat (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online_delay            (tx_online_delay),
    .tx_data_en                 (tx_data_en),
    .rx_online_delay            (rx_online_delay),
    .tx_stb_userbit             (tx_stb_userbit),
    .ustrm_word                 (ustrm_word),
    .dstrm_word                 (dstrm_word),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status)
  );

endmodule
